/* source/genesis_pkg.sv */
/*
 * genesis core shared definitions
 * bridge and load stream types, settings address map, cartridge header
 * offsets, pad key positions and the cartridge compatibility tables
 */
`default_nettype none

package genesis_pkg;

	typedef logic [31:0] addr_t;      // bridge address
	typedef logic [31:0] word_t;      // bridge data
	typedef logic [24:0] load_addr_t; // byte address of the rom stream
	typedef logic [15:0] load_data_t;
	typedef logic [15:0] key_t;       // raw pad bitmap from the host
	typedef logic [11:0] joy_t;       // console pad layout
	typedef logic [63:0] cart_id_t;   // eight ascii bytes
	typedef logic [1:0]  region_t;    // 0 japan, 1 usa, 2 europe

	typedef enum logic [3:0] {
		quirk_none,
		quirk_sram,
		quirk_sram00,
		quirk_eeprom,
		quirk_noram,
		quirk_fifo,
		quirk_pier,
		quirk_svp,
		quirk_fmbusy,
		quirk_schan
	} quirk_e;

	//////////////////////////////////////////////////
	// settings address map
	localparam addr_t addr_audio_filter  = 32'h00F0_0000;
	localparam addr_t addr_fm_chip       = 32'h00A0_0000;
	localparam addr_t addr_cpu_turbo     = 32'h00C0_0000;
	localparam addr_t addr_multitap      = 32'h0000_0000;
	localparam addr_t addr_ar_correction = 32'h0000_0010;
	localparam addr_t addr_composite     = 32'h0000_0020;
	localparam addr_t addr_obj_limit_high = 32'h0000_0030;
	localparam addr_t addr_fm_enable     = 32'h0000_0040;
	localparam addr_t addr_psg_enable    = 32'h0000_0050;
	localparam addr_t addr_hifi_pcm      = 32'h0000_0060;
	localparam addr_t addr_region        = 32'h00E0_0000; // read only

	//////////////////////////////////////////////////
	// cartridge header offsets
	localparam load_addr_t hdr_id_0     = 25'h182;
	localparam load_addr_t hdr_id_1     = 25'h184;
	localparam load_addr_t hdr_id_2     = 25'h186;
	localparam load_addr_t hdr_id_3     = 25'h188;
	localparam load_addr_t hdr_id_4     = 25'h18A;
	localparam load_addr_t hdr_id_5     = 25'h18C; // product code complete here
	localparam load_addr_t hdr_region_0 = 25'h1F0;
	localparam load_addr_t hdr_region_1 = 25'h1F2;
	localparam load_addr_t hdr_end      = 25'h200;

	localparam int sync_stages = 3;

	// host key bit per console button
	localparam int pad_up    = 0;
	localparam int pad_down  = 1;
	localparam int pad_left  = 2;
	localparam int pad_right = 3;
	localparam int pad_b     = 4;
	localparam int pad_c     = 5;
	localparam int pad_y     = 6;
	localparam int pad_a     = 7;
	localparam int pad_x     = 8;
	localparam int pad_z     = 9;
	localparam int pad_mode  = 14;
	localparam int pad_start = 15;

	//////////////////////////////////////////////////
	// compatibility tables
	localparam int quirk_count = 25;
	localparam int gun_count   = 5;

	localparam cart_id_t quirk_ids [quirk_count] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ",
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  ", "T-113016",
		"T-89016 ", "T-574023", "T-574013", "MK-1229 ", "G-7001  ",
		"T-35036 ", "T-25073 ", "MK-1137-", "T-68???-", " GM 0000"
	};

	localparam quirk_e quirk_kinds [quirk_count] = '{
		quirk_sram,   quirk_sram,   quirk_sram,   quirk_sram,   quirk_sram,
		quirk_eeprom, quirk_eeprom, quirk_eeprom, quirk_eeprom, quirk_eeprom,
		quirk_eeprom, quirk_eeprom, quirk_eeprom, quirk_eeprom, quirk_noram,
		quirk_fifo,   quirk_pier,   quirk_pier,   quirk_svp,    quirk_svp,
		quirk_fmbusy, quirk_fmbusy, quirk_fmbusy, quirk_schan,  quirk_sram00
	};

	// light gun titles, type 1 is the two-button gun
	localparam cart_id_t gun_ids [gun_count] = '{
		"MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"
	};
	localparam logic gun_types [gun_count] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
	localparam logic [7:0] gun_delays [gun_count] = '{8'd100, 8'd52, 8'd30, 8'd120, 8'd126};
	localparam logic [7:0] gun_delay_default = 8'd44;

endpackage

`default_nettype wire

/* source/core_settings.sv */
/*
 * core settings bank
 * host writes single-bit and two-bit options over the bridge,
 * reads return the detected region
 */
`default_nettype none

module core_settings import genesis_pkg::*; (
	input  wire         clk_sys,
	input  wire         rst_n,
	input  wire addr_t  bridge_addr,
	input  wire         bridge_wr,
	input  wire word_t  bridge_wr_data,
	input  wire region_t region_req,
	output word_t       bridge_rd_data,
	output logic [1:0]  cpu_turbo,
	output logic        multitap_en,
	output logic        ar_correction,
	output logic        composite_en,
	output logic        obj_limit_high,
	output logic        fm_enable,
	output logic        psg_enable,
	output logic        hifi_pcm,
	output logic [1:0]  audio_filter,
	output logic        fm_chip
);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_turbo      <= 2'd0;
			multitap_en    <= 1'b0;
			ar_correction  <= 1'b0;
			composite_en   <= 1'b0;
			obj_limit_high <= 1'b1; // full sprite count by default
			fm_enable      <= 1'b1;
			psg_enable     <= 1'b1;
			hifi_pcm       <= 1'b1;
			audio_filter   <= 2'd0;
			fm_chip        <= 1'b0;
		end else if (bridge_wr) begin
			case (bridge_addr) // exact match only
				addr_audio_filter:   audio_filter   <= bridge_wr_data[1:0];
				addr_fm_chip:        fm_chip        <= bridge_wr_data[0];
				addr_cpu_turbo:      cpu_turbo      <= bridge_wr_data[1:0];
				addr_multitap:       multitap_en    <= bridge_wr_data[0];
				addr_ar_correction:  ar_correction  <= bridge_wr_data[0];
				addr_composite:      composite_en   <= bridge_wr_data[0];
				addr_obj_limit_high: obj_limit_high <= bridge_wr_data[0];
				addr_fm_enable:      fm_enable      <= bridge_wr_data[0];
				addr_psg_enable:     psg_enable     <= bridge_wr_data[0];
				addr_hifi_pcm:       hifi_pcm       <= bridge_wr_data[0];
				default: ;
			endcase
		end
	end

	// read mux, same cycle
	always_comb begin
		if (bridge_addr == addr_region)
			bridge_rd_data = {30'd0, region_req};
		else
			bridge_rd_data = '0;
	end

	a_wr_known: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(bridge_wr));

endmodule

`default_nettype wire

/* source/header_scanner.sv */
/*
 * cartridge header scanner
 * watches the rom stream, captures the product code, decodes the region
 * and holds the console in reset from header end until the load finishes
 */
`default_nettype none

module header_scanner import genesis_pkg::*; (
	input  wire             clk_sys,
	input  wire             rst_n,
	input  wire             load_active,
	input  wire             load_wr,
	input  wire load_addr_t load_addr,
	input  wire load_data_t load_data,
	output region_t         region_req,
	output logic            region_hold,
	output load_addr_t      rom_size,
	output cart_id_t        cart_id,
	output logic            id_start,
	output logic            id_done
);

	logic       active_q, load_rise, load_fall, wr_en;
	logic       fall_q;
	logic       header_ready, ready_q;
	logic       hdr_j, hdr_u, hdr_e;
	logic [2:0] flags_next; // {e, u, j}
	logic [3:0] hrgn;
	load_addr_t last_addr;

	assign load_rise = load_active & ~active_q;
	assign load_fall = ~load_active & active_q;
	assign wr_en     = load_wr & load_active;
	assign hrgn      = load_data[3:0] - 4'd7; // 'A'..'F' to 10..15

	function automatic logic [2:0] mark_letter(input logic [7:0] c, input logic [2:0] f);
		logic [2:0] r;
		r = f;
		if (c == "J")
			r[0] = 1'b1;
		else if (c == "U")
			r[1] = 1'b1;
		else if (c == "E")
			r[2] = 1'b1;
		return r;
	endfunction

	//////////////////////////////////////////////////
	// region byte decode
	always_comb begin
		flags_next = {hdr_e, hdr_u, hdr_j};
		if (load_addr == hdr_region_0) begin
			if (load_data[7:0] == "J" || load_data[7:0] == "U" || load_data[7:0] == "E")
				flags_next = mark_letter(load_data[7:0], flags_next);
			else if (load_data[7:0] >= "0" && load_data[7:0] <= "9")
				flags_next = {load_data[3], load_data[2], load_data[0]}; // hex bitmask form
			else if (load_data[7:0] >= "A" && load_data[7:0] <= "F")
				flags_next = {hrgn[3], hrgn[2], hrgn[0]};
			flags_next = mark_letter(load_data[15:8], flags_next);
		end else if (load_addr == hdr_region_1) begin
			flags_next = mark_letter(load_data[7:0], flags_next);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			{hdr_e, hdr_u, hdr_j} <= 3'b000;
		else if (load_rise)
			{hdr_e, hdr_u, hdr_j} <= 3'b000; // new image
		else if (wr_en)
			{hdr_e, hdr_u, hdr_j} <= flags_next;
	end

	//////////////////////////////////////////////////
	// load control and region request
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_q     <= 1'b0;
			fall_q       <= 1'b0;
			header_ready <= 1'b0;
			ready_q      <= 1'b0;
			region_req   <= 2'd1;
			region_hold  <= 1'b0;
			rom_size     <= '0;
			id_start     <= 1'b0;
			id_done      <= 1'b0;
		end else begin
			active_q <= load_active;
			fall_q   <= load_fall;
			ready_q  <= header_ready;
			id_start <= load_rise;
			id_done  <= wr_en && (load_addr == hdr_id_5);

			if (load_fall)
				header_ready <= 1'b0;
			else if (wr_en && load_addr == hdr_end)
				header_ready <= 1'b1;

			if (header_ready && !ready_q) begin
				region_hold <= 1'b1;
				if (hdr_u)      region_req <= 2'd1; // usa wins
				else if (hdr_e) region_req <= 2'd2;
				else if (hdr_j) region_req <= 2'd0;
				else            region_req <= 2'd1;
			end
			if (load_fall)
				region_hold <= 1'b0;

			if (fall_q)
				rom_size <= last_addr + 25'd2; // last word plus its width
		end
	end

	// product code bytes, swapped to string order
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			last_addr <= load_addr;
			case (load_addr)
				hdr_id_0: cart_id[63:56] <= load_data[15:8];
				hdr_id_1: cart_id[55:40] <= {load_data[7:0], load_data[15:8]};
				hdr_id_2: cart_id[39:24] <= {load_data[7:0], load_data[15:8]};
				hdr_id_3: cart_id[23:8]  <= {load_data[7:0], load_data[15:8]};
				hdr_id_4: cart_id[7:0]   <= load_data[7:0];
				default: ;
			endcase
		end
	end

	a_region_legal: assert property (@(posedge clk_sys) disable iff (!rst_n)
		region_req != 2'd3);

endmodule

`default_nettype wire

/* source/quirk_table.sv */
/*
 * compatibility lookup
 * matches the product code against the quirk and light gun tables
 */
`default_nettype none

module quirk_table import genesis_pkg::*; (
	input  wire           clk_sys,
	input  wire           rst_n,
	input  wire cart_id_t cart_id,
	input  wire           id_start,
	input  wire           id_done,
	output logic          sram_quirk,
	output logic          sram00_quirk,
	output logic          eeprom_quirk,
	output logic          noram_quirk,
	output logic          fifo_quirk,
	output logic          pier_quirk,
	output logic          svp_quirk,
	output logic          fmbusy_quirk,
	output logic          schan_quirk,
	output logic          gun_type,
	output logic [7:0]    gun_sensor_delay
);

	quirk_e     hit;
	logic [8:0] flag_next, flag_q; // bit n is quirk kind n+1
	logic       gun_type_next;
	logic [7:0] gun_delay_next;

	// first table match wins
	always_comb begin
		hit = quirk_none;
		for (int i = 0; i < quirk_count; i++) begin
			if (hit == quirk_none && cart_id == quirk_ids[i])
				hit = quirk_kinds[i];
		end
		for (int k = 1; k <= 9; k++)
			flag_next[k-1] = (hit == quirk_e'(k));
	end

	always_comb begin
		gun_type_next  = 1'b0;
		gun_delay_next = gun_delay_default; // no gun title
		for (int i = 0; i < gun_count; i++) begin
			if (cart_id == gun_ids[i]) begin
				gun_type_next  = gun_types[i];
				gun_delay_next = gun_delays[i];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			flag_q           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= gun_delay_default;
		end else if (id_start) begin
			flag_q <= '0; // download started
		end else if (id_done) begin
			flag_q           <= flag_next;
			gun_type         <= gun_type_next;
			gun_sensor_delay <= gun_delay_next;
		end
	end

	assign sram_quirk   = flag_q[0];
	assign sram00_quirk = flag_q[1];
	assign eeprom_quirk = flag_q[2];
	assign noram_quirk  = flag_q[3];
	assign fifo_quirk   = flag_q[4];
	assign pier_quirk   = flag_q[5];
	assign svp_quirk    = flag_q[6];
	assign fmbusy_quirk = flag_q[7];
	assign schan_quirk  = flag_q[8];

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0({sram_quirk, sram00_quirk, eeprom_quirk, noram_quirk, fifo_quirk,
			pier_quirk, svp_quirk, fmbusy_quirk, schan_quirk}));

endmodule

`default_nettype wire

/* source/pad_input.sv */
/*
 * pad front end
 * synchronizes the four host pads and the menu flag, then remaps keys
 */
`default_nettype none

module pad_input import genesis_pkg::*; (
	input  wire       clk_sys,
	input  wire       rst_n,
	input  wire key_t cont1_key,
	input  wire key_t cont2_key,
	input  wire key_t cont3_key,
	input  wire key_t cont4_key,
	input  wire       in_menu,
	output joy_t      joy_0,
	output joy_t      joy_1,
	output joy_t      joy_2,
	output joy_t      joy_3,
	output logic      pause
);

	key_t                   key_in [4];
	key_t                   key_sync [4][sync_stages];
	logic [sync_stages-1:0] menu_sync;

	// console order, bit 11 first
	function automatic joy_t remap(input key_t k);
		return {k[pad_z], k[pad_y], k[pad_x], k[pad_mode], k[pad_start], k[pad_b],
			k[pad_c], k[pad_a], k[pad_up], k[pad_down], k[pad_left], k[pad_right]};
	endfunction

	assign key_in[0] = cont1_key;
	assign key_in[1] = cont2_key;
	assign key_in[2] = cont3_key;
	assign key_in[3] = cont4_key;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int p = 0; p < 4; p++)
				for (int s = 0; s < sync_stages; s++)
					key_sync[p][s] <= '0;
			menu_sync <= '0;
		end else begin
			for (int p = 0; p < 4; p++) begin
				key_sync[p][0] <= key_in[p];
				for (int s = 1; s < sync_stages; s++)
					key_sync[p][s] <= key_sync[p][s-1];
			end
			menu_sync <= {menu_sync[sync_stages-2:0], in_menu};
		end
	end

	assign joy_0 = remap(key_sync[0][sync_stages-1]);
	assign joy_1 = remap(key_sync[1][sync_stages-1]);
	assign joy_2 = remap(key_sync[2][sync_stages-1]);
	assign joy_3 = remap(key_sync[3][sync_stages-1]);
	assign pause = menu_sync[sync_stages-1];

endmodule

`default_nettype wire

/* source/genesis_core_top.sv */
/*
 * genesis core user-side control
 * settings bank, header scanner, quirk lookup and pad front end
 */
`default_nettype none

module genesis_core_top import genesis_pkg::*; (
	input  wire             clk_sys,
	input  wire             rst_n,
	// bridge
	input  wire addr_t      bridge_addr,
	input  wire             bridge_wr,
	input  wire word_t      bridge_wr_data,
	output word_t           bridge_rd_data,
	// rom stream
	input  wire             load_active,
	input  wire             load_wr,
	input  wire load_addr_t load_addr,
	input  wire load_data_t load_data,
	// pads
	input  wire key_t       cont1_key,
	input  wire key_t       cont2_key,
	input  wire key_t       cont3_key,
	input  wire key_t       cont4_key,
	input  wire             in_menu,
	output joy_t            joy_0,
	output joy_t            joy_1,
	output joy_t            joy_2,
	output joy_t            joy_3,
	output logic            pause,
	// settings
	output logic [1:0]      cpu_turbo,
	output logic            multitap_en,
	output logic            ar_correction,
	output logic            composite_en,
	output logic            obj_limit_high,
	output logic            fm_enable,
	output logic            psg_enable,
	output logic            hifi_pcm,
	output logic [1:0]      audio_filter,
	output logic            fm_chip,
	// cartridge
	output region_t         region_req,
	output logic            region_hold, // console reset level
	output load_addr_t      rom_size,
	output logic            sram_quirk,
	output logic            sram00_quirk,
	output logic            eeprom_quirk,
	output logic            noram_quirk,
	output logic            fifo_quirk,
	output logic            pier_quirk,
	output logic            svp_quirk,
	output logic            fmbusy_quirk,
	output logic            schan_quirk,
	output logic            gun_type,
	output logic [7:0]      gun_sensor_delay
);

	cart_id_t cart_id;
	logic     id_start, id_done;

	core_settings settings0 (
		.clk_sys, .rst_n, .bridge_addr, .bridge_wr, .bridge_wr_data, .region_req,
		.bridge_rd_data, .cpu_turbo, .multitap_en, .ar_correction, .composite_en,
		.obj_limit_high, .fm_enable, .psg_enable, .hifi_pcm, .audio_filter, .fm_chip
	);

	header_scanner scanner0 (
		.clk_sys, .rst_n, .load_active, .load_wr, .load_addr, .load_data,
		.region_req, .region_hold, .rom_size, .cart_id, .id_start, .id_done
	);

	quirk_table quirks0 (
		.clk_sys, .rst_n, .cart_id, .id_start, .id_done,
		.sram_quirk, .sram00_quirk, .eeprom_quirk, .noram_quirk, .fifo_quirk,
		.pier_quirk, .svp_quirk, .fmbusy_quirk, .schan_quirk,
		.gun_type, .gun_sensor_delay
	);

	pad_input pads0 (
		.clk_sys, .rst_n, .cont1_key, .cont2_key, .cont3_key, .cont4_key, .in_menu,
		.joy_0, .joy_1, .joy_2, .joy_3, .pause
	);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * 8 ns clock, reset held low for the first four cycles
 */
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period = 4;

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1; // released away from the active edge
	end

endmodule

`default_nettype wire

/* verification/tb_genesis_core.sv */
/*
 * testbench for the genesis core control logic
 * drives settings writes, rom header streams and pad keys on the falling edge
 * and checks every response against reference models at the next rising edge
 */
`default_nettype none

module tb_genesis_core import genesis_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period_ns = 8;
	localparam int budget_cycles = 25_000; // about four times the longest run
	localparam int pad_cycles    = 200;

	// check selectors, 0..9 are the settings in set_addr order
	localparam int sel_region    = 10;
	localparam int sel_rd_data   = 11;
	localparam int sel_hold      = 12;
	localparam int sel_rom_size  = 13;
	localparam int sel_quirks    = 14;
	localparam int sel_gun_type  = 15;
	localparam int sel_gun_delay = 16;
	localparam int sel_joy       = 17; // joy_0 .. joy_3
	localparam int sel_pause     = 21;

	localparam addr_t set_addr [10] = '{addr_audio_filter, addr_fm_chip, addr_cpu_turbo,
		addr_multitap, addr_ar_correction, addr_composite, addr_obj_limit_high,
		addr_fm_enable, addr_psg_enable, addr_hifi_pcm};
	localparam logic [1:0] set_mask [10] = '{2'd3, 2'd1, 2'd3, 2'd1, 2'd1, 2'd1, 2'd1,
		2'd1, 2'd1, 2'd1};
	localparam logic [1:0] set_reset [10] = '{2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd1,
		2'd1, 2'd1, 2'd1};
	localparam logic [7:0] jue_chars [3] = '{"J", "U", "E"};

	string set_name [10] = '{"audio_filter", "fm_chip", "cpu_turbo", "multitap_en",
		"ar_correction", "composite_en", "obj_limit_high", "fm_enable", "psg_enable",
		"hifi_pcm"};

	logic clk_sys, rst_n;
	addr_t bridge_addr;
	logic bridge_wr;
	word_t bridge_wr_data, bridge_rd_data;
	logic load_active, load_wr;
	load_addr_t load_addr, rom_size;
	load_data_t load_data;
	key_t cont1_key, cont2_key, cont3_key, cont4_key;
	logic in_menu, pause;
	joy_t joy_0, joy_1, joy_2, joy_3;
	logic [1:0] cpu_turbo, audio_filter;
	logic multitap_en, ar_correction, composite_en, obj_limit_high;
	logic fm_enable, psg_enable, hifi_pcm, fm_chip;
	region_t region_req;
	logic region_hold;
	logic sram_quirk, sram00_quirk, eeprom_quirk, noram_quirk, fifo_quirk;
	logic pier_quirk, svp_quirk, fmbusy_quirk, schan_quirk;
	logic gun_type;
	logic [7:0] gun_sensor_delay;

	logic [1:0]  set_model [10];
	key_t        key_hist [4][pad_cycles];
	logic        menu_hist [pad_cycles];
	int          chk_sel [$];
	logic [31:0] chk_exp [$];
	string       chk_name [$];
	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock_gen clk0 (.clk_sys, .rst_n);

	genesis_core_top dut0 (.*);

	//////////////////////////////////////////////////
	// reference models

	// Z Y X mode start B C A up down left right
	function automatic joy_t remap_keys(input key_t k);
		return {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7], k[0], k[1], k[2], k[3]};
	endfunction

	function automatic logic [2:0] letter_flags(input logic [7:0] c); // {e, u, j}
		return {c == "E", c == "U", c == "J"};
	endfunction

	function automatic region_t decode_region(input logic [7:0] c0, c1, c2);
		logic [2:0] f;
		logic [3:0] n;
		if (c0 == "J" || c0 == "U" || c0 == "E") begin
			f = letter_flags(c0);
		end else if (c0 >= "0" && c0 <= "9") begin
			n = c0[3:0];
			f = {n[3], n[2], n[0]};
		end else if (c0 >= "A" && c0 <= "F") begin
			n = 4'(c0 - "A" + 8'd10); // hex digit value
			f = {n[3], n[2], n[0]};
		end else begin
			f = 3'b000;
		end
		f = f | letter_flags(c1) | letter_flags(c2);
		if (f[1])
			return 2'd1;
		else if (f[2])
			return 2'd2;
		else if (f[0])
			return 2'd0;
		return 2'd1;
	endfunction

	function automatic logic [8:0] quirk_bits(input cart_id_t id);
		for (int i = 0; i < quirk_count; i++)
			if (quirk_ids[i] == id)
				return 9'd1 << (int'(quirk_kinds[i]) - 1);
		return 9'd0;
	endfunction

	function automatic logic [8:0] gun_setting(input cart_id_t id); // {type, delay}
		for (int i = 0; i < gun_count; i++)
			if (gun_ids[i] == id)
				return {gun_types[i], gun_delays[i]};
		return {1'b0, 8'd44};
	endfunction

	// byte of the rom image, product code from 0x183 and region chars at 0x1f0
	function automatic logic [7:0] image_byte(input int a, input cart_id_t id,
			input logic [23:0] rgn);
		if (a >= 'h183 && a <= 'h18A)
			return id[8 * (7 - (a - 'h183)) +: 8];
		if (a >= 'h1F0 && a <= 'h1F2)
			return rgn[8 * (a - 'h1F0) +: 8];
		return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'(a >> 24);
	endfunction

	function automatic logic [31:0] observe(input int sel);
		case (sel)
			0: return {30'd0, audio_filter};
			1: return {31'd0, fm_chip};
			2: return {30'd0, cpu_turbo};
			3: return {31'd0, multitap_en};
			4: return {31'd0, ar_correction};
			5: return {31'd0, composite_en};
			6: return {31'd0, obj_limit_high};
			7: return {31'd0, fm_enable};
			8: return {31'd0, psg_enable};
			9: return {31'd0, hifi_pcm};
			sel_region: return {30'd0, region_req};
			sel_rd_data: return bridge_rd_data;
			sel_hold: return {31'd0, region_hold};
			sel_rom_size: return {7'd0, rom_size};
			sel_quirks: return {23'd0, schan_quirk, fmbusy_quirk, svp_quirk, pier_quirk,
				fifo_quirk, noram_quirk, eeprom_quirk, sram00_quirk, sram_quirk};
			sel_gun_type: return {31'd0, gun_type};
			sel_gun_delay: return {24'd0, gun_sensor_delay};
			sel_joy: return {20'd0, joy_0};
			sel_joy + 1: return {20'd0, joy_1};
			sel_joy + 2: return {20'd0, joy_2};
			sel_joy + 3: return {20'd0, joy_3};
			sel_pause: return {31'd0, pause};
			default: return 32'hDEAD_BEEF; // unknown selector never matches
		endcase
	endfunction

	//////////////////////////////////////////////////
	// stimulus helpers

	task automatic expect_value(input int sel, input logic [31:0] value, input string name);
		chk_sel.push_back(sel);
		chk_exp.push_back(value);
		chk_name.push_back(name);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	function automatic logic [7:0] random_region_char();
		int kind;
		kind = int'($urandom_range(0, 3));
		case (kind)
			0: return jue_chars[$urandom_range(0, 2)];
			1: return 8'("0" + $urandom_range(0, 9));
			2: return 8'("A" + $urandom_range(0, 5));
			default: return 8'($urandom); // anything, often ignored
		endcase
	endfunction

	function automatic logic [23:0] random_region();
		return {random_region_char(), random_region_char(), random_region_char()};
	endfunction

	task automatic check_settings();
		for (int i = 0; i < 10; i++)
			expect_value(i, {30'd0, set_model[i]}, set_name[i]);
		expect_value(sel_rd_data, 32'd0, "bridge read of a write-only address");
	endtask

	task automatic write_setting(input addr_t addr, input word_t data);
		bridge_wr      = 1'b1;
		bridge_addr    = addr;
		bridge_wr_data = data;
		for (int i = 0; i < 10; i++)
			if (addr == set_addr[i])
				set_model[i] = data[1:0] & set_mask[i];
		@(negedge clk_sys);
		bridge_wr = 1'b0;
		check_settings();
		@(negedge clk_sys);
	endtask

	function automatic addr_t unmapped_addr();
		addr_t a;
		logic  hit;
		do begin
			a   = addr_t'($urandom);
			hit = (a == addr_region);
			for (int i = 0; i < 10; i++)
				hit |= (a == set_addr[i]);
		end while (hit);
		return a;
	endfunction

	// one download from 0x180 up to tail words past the header end
	task automatic load_image(input cart_id_t id, input logic [23:0] rgn, input int tail);
		int         last;
		logic [8:0] quirks, gun;
		region_t    rgn_exp;
		last    = int'(hdr_end) + 2 * tail;
		quirks  = quirk_bits(id);
		gun     = gun_setting(id);
		rgn_exp = decode_region(rgn[7:0], rgn[15:8], rgn[23:16]);
		@(negedge clk_sys);
		load_active = 1'b1;
		repeat (3) @(negedge clk_sys);
		for (int a = 'h180; a <= last; a += 2) begin
			load_wr   = 1'b1;
			load_addr = load_addr_t'(a);
			load_data = {image_byte(a + 1, id, rgn), image_byte(a, id, rgn)};
			if (a == int'(hdr_id_5) + 2)
				expect_value(sel_quirks, 32'd0, "quirk flags before lookup");
			if (a == int'(hdr_id_5) + 4) begin
				expect_value(sel_quirks, {23'd0, quirks}, "quirk flags");
				expect_value(sel_gun_type, {31'd0, gun[8]}, "gun_type");
				expect_value(sel_gun_delay, {24'd0, gun[7:0]}, "gun_sensor_delay");
			end
			if (a == int'(hdr_end) + 2)
				expect_value(sel_hold, 32'd0, "region_hold before header end");
			if (a == int'(hdr_end) + 4) begin
				bridge_addr = addr_region;
				expect_value(sel_hold, 32'd1, "region_hold after header end");
				expect_value(sel_region, {30'd0, rgn_exp}, "region_req");
				expect_value(sel_rd_data, {30'd0, rgn_exp}, "region bridge read");
			end
			@(negedge clk_sys);
		end
		load_wr = 1'b0;
		@(negedge clk_sys);
		load_active = 1'b0;
		expect_value(sel_hold, 32'd1, "region_hold at load end");
		@(negedge clk_sys);
		expect_value(sel_hold, 32'd0, "region_hold after load end");
		@(negedge clk_sys);
		expect_value(sel_rom_size, 32'(last + 2), "rom_size");
		bridge_addr = '0;
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// compare at the rising edge, before the DUT registers update
	initial begin : compare
		int          sel;
		logic [31:0] want, got;
		string       name;
		forever begin
			@(posedge clk_sys);
			while (chk_sel.size() > 0) begin
				sel  = chk_sel.pop_front();
				want = chk_exp.pop_front();
				name = chk_name.pop_front();
				got  = observe(sel);
				checks++;
				assert (got === want) else begin
					$display("mismatch at %0d ns: %s is %0h, expected %0h",
						$time, name, got, want);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		#(budget_cycles * clk_period_ns);
		$display("timeout: no result after %0d clock cycles", budget_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : stimulus
		int err0;
		void'($urandom(32'h1c99654d));
		bridge_addr    = '0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;
		load_active    = 1'b0;
		load_wr        = 1'b0;
		load_addr      = '0;
		load_data      = '0;
		cont1_key      = '0;
		cont2_key      = '0;
		cont3_key      = '0;
		cont4_key      = '0;
		in_menu        = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge clk_sys);

		// reset values, then every setting and a few stray writes
		err0 = errors;
		for (int i = 0; i < 10; i++)
			set_model[i] = set_reset[i];
		check_settings();
		expect_value(sel_region, 32'd1, "region_req after reset");
		expect_value(sel_hold, 32'd0, "region_hold after reset");
		expect_value(sel_rom_size, 32'd0, "rom_size after reset");
		expect_value(sel_quirks, 32'd0, "quirk flags after reset");
		expect_value(sel_gun_type, 32'd0, "gun_type after reset");
		expect_value(sel_gun_delay, 32'd44, "gun_sensor_delay after reset");
		for (int p = 0; p < 4; p++)
			expect_value(sel_joy + p, 32'd0, $sformatf("joy_%0d after reset", p));
		expect_value(sel_pause, 32'd0, "pause after reset");
		@(negedge clk_sys);
		for (int r = 0; r < 8; r++) begin
			for (int i = 0; i < 10; i++)
				write_setting(set_addr[i], word_t'($urandom));
			write_setting(unmapped_addr(), word_t'($urandom));
			write_setting(set_addr[r] ^ 32'h8, word_t'($urandom)); // near miss
		end
		finish_test("settings", err0);

		err0 = errors;
		for (int n = 0; n < 24; n++)
			load_image({$urandom, $urandom}, random_region(), int'($urandom_range(3, 8)));
		finish_test("region", err0);

		err0 = errors;
		for (int i = 0; i < quirk_count; i++)
			load_image(quirk_ids[i], random_region(), 3);
		for (int i = 0; i < gun_count; i++)
			load_image(gun_ids[i], random_region(), 3);
		load_image("UNKNOWN ", random_region(), 3);
		finish_test("quirks", err0);

		err0 = errors;
		for (int n = 0; n < pad_cycles + 3; n++) begin
			if (n < pad_cycles) begin
				for (int p = 0; p < 4; p++)
					key_hist[p][n] = key_t'($urandom);
				menu_hist[n] = 1'($urandom);
				cont1_key    = key_hist[0][n];
				cont2_key    = key_hist[1][n];
				cont3_key    = key_hist[2][n];
				cont4_key    = key_hist[3][n];
				in_menu      = menu_hist[n];
			end
			if (n >= 3) begin
				for (int p = 0; p < 4; p++)
					expect_value(sel_joy + p, {20'd0, remap_keys(key_hist[p][n-3])},
						$sformatf("joy_%0d", p));
				expect_value(sel_pause, {31'd0, menu_hist[n-3]}, "pause");
			end
			@(negedge clk_sys);
		end
		finish_test("pads", err0);

		err0 = errors;
		for (int n = 0; n < 4; n++)
			load_image({$urandom, $urandom}, random_region(), int'($urandom_range(3, 60)));
		finish_test("load end", err0);

		$display("%0d of %0d tests ok, %0d checks, %0d errors",
			tests_run - tests_failed, tests_run, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
source/genesis_pkg.sv
source/core_settings.sv
source/header_scanner.sv
source/quirk_table.sv
source/pad_input.sv
source/genesis_core_top.sv
verification/tb_clock_gen.sv
verification/tb_genesis_core.sv

/* Makefile */
# Verilator flow for the genesis core control logic

TOP := tb_genesis_core
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f \
		--top-module genesis_core_top

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
